// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the icache testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps --top-module icache_tb \
		-f icache_top.f -Mdir obj_dir -o icache_tb_sim
	./obj_dir/icache_tb_sim

clean:
	rm -rf obj_dir

// ==== icache_hit_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_hit_select #(
    parameter int INDEX_WIDTH  = 6,
    parameter int OFFSET_WIDTH = 4,
    parameter int WAY_NUM      = 2
) (
    input  logic                                      cpu_req_1,
    input  logic                                      cpu_req_2,
    input  icache_pkg::addr_t                         instr_addr_1,
    input  icache_pkg::addr_t                         instr_addr_2,
    input  logic [WAY_NUM-1:0]                        way_hit,
    input  logic [WAY_NUM*(2**(OFFSET_WIDTH-2))*32-1:0] way_lines,
    output logic                                      miss,
    output logic                                      cpu_addr_ok,
    output logic                                      cpu_data_ok,
    output logic                                      second_data_ok,
    output icache_pkg::word_t                         instr_rdata_1,
    output icache_pkg::word_t                         instr_rdata_2
);

    localparam int TAG_WIDTH      = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int TAG_LSB        = INDEX_WIDTH + OFFSET_WIDTH;
    localparam int LINE_WORDS     = 2 ** (OFFSET_WIDTH - 2);
    localparam int LINE_BITS      = LINE_WORDS * 32;
    localparam int WORD_SEL_WIDTH = OFFSET_WIDTH - 2;
    localparam int SEL_WIDTH      = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1;

    logic                      hit;
    logic [SEL_WIDTH-1:0]      hit_way;
    logic [LINE_BITS-1:0]      hit_line;
    logic [WORD_SEL_WIDTH-1:0] offset_1;
    logic [WORD_SEL_WIDTH-1:0] offset_2;
    logic [TAG_WIDTH-1:0]      tag_1;
    logic [TAG_WIDTH-1:0]      tag_2;
    logic                      same_line;
    icache_pkg::word_t         word_1;
    icache_pkg::word_t         word_2;

    assign hit = |way_hit;

    // at most one way hits, so OR-ing the way numbers gives its number
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (way_hit[w]) begin
                hit_way |= SEL_WIDTH'(w);
            end
        end
    end

    assign hit_line = way_lines[hit_way * LINE_BITS +: LINE_BITS];

    assign offset_1 = instr_addr_1[OFFSET_WIDTH-1:2];
    assign offset_2 = instr_addr_2[OFFSET_WIDTH-1:2];
    assign word_1   = hit_line[offset_1 * 32 +: 32];
    assign word_2   = hit_line[offset_2 * 32 +: 32];

    // slot 2 shares the line only if tag and index both match
    assign tag_1     = instr_addr_1[31:TAG_LSB];
    assign tag_2     = instr_addr_2[31:TAG_LSB];
    assign same_line = (tag_1 == tag_2) &&
                       (instr_addr_1[TAG_LSB-1:OFFSET_WIDTH] == instr_addr_2[TAG_LSB-1:OFFSET_WIDTH]);

    assign miss           = cpu_req_1 && !hit;
    assign cpu_addr_ok    = cpu_req_1 && hit;
    assign cpu_data_ok    = cpu_req_1 && hit;
    assign second_data_ok = cpu_data_ok && cpu_req_2 && same_line;

    assign instr_rdata_1 = word_1;
    assign instr_rdata_2 = second_data_ok ? word_2 : '0;

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // byte address as seen on the cpu and memory ports
    typedef logic [31:0] addr_t;

    // one instruction word
    typedef logic [31:0] word_t;

    // refill sequencing
    // fetch covers address issue and data return while write is the single array update cycle
    typedef enum logic [1:0] {
        REFILL_IDLE  = 2'd0,
        REFILL_FETCH = 2'd1,
        REFILL_WRITE = 2'd2
    } refill_state_e;

    // default geometry of 64 sets with 16-byte lines
    localparam int DEFAULT_INDEX_WIDTH = 6;

    // 4 words per line
    localparam int DEFAULT_OFFSET_WIDTH = 4;

    // two ways per set
    localparam int DEFAULT_WAY_NUM = 2;

endpackage

`default_nettype wire

// ==== icache_refill_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_refill_ctrl #(
    parameter int INDEX_WIDTH  = 6,
    parameter int OFFSET_WIDTH = 4
) (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                miss,
    input  icache_pkg::addr_t                   instr_addr_1,
    input  logic                                mem_addr_ok,
    input  logic                                mem_data_ok,
    input  icache_pkg::word_t                   mem_read_data,
    output logic                                mem_req,
    output icache_pkg::addr_t                   mem_read_addr,
    output logic [(2**(OFFSET_WIDTH-2))*32-1:0] fill_line,
    output logic                                fill_valid
);

    localparam int TAG_WIDTH      = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int TAG_LSB        = INDEX_WIDTH + OFFSET_WIDTH;
    localparam int LINE_WORDS     = 2 ** (OFFSET_WIDTH - 2);
    localparam int WORD_SEL_WIDTH = OFFSET_WIDTH - 2;

    localparam logic [WORD_SEL_WIDTH-1:0] LAST_WORD = WORD_SEL_WIDTH'(LINE_WORDS - 1);

    icache_pkg::refill_state_e state_q;
    icache_pkg::refill_state_e state_d;

    // address count carries one extra bit that flags all beats issued
    logic [WORD_SEL_WIDTH:0]   addr_cnt_q;
    logic [WORD_SEL_WIDTH-1:0] data_cnt_q;
    logic                      addr_done;
    logic                      fetching;
    logic                      data_beat;

    logic [TAG_WIDTH-1:0]   miss_tag;
    logic [INDEX_WIDTH-1:0] miss_index;
    icache_pkg::addr_t      line_base;
    icache_pkg::addr_t      beat_offset;

    assign fetching   = (state_q == icache_pkg::REFILL_FETCH);
    assign addr_done  = addr_cnt_q[WORD_SEL_WIDTH];
    assign data_beat  = fetching && mem_data_ok;
    assign fill_valid = (state_q == icache_pkg::REFILL_WRITE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            icache_pkg::REFILL_IDLE: begin
                if (miss) begin
                    state_d = icache_pkg::REFILL_FETCH;
                end
            end
            icache_pkg::REFILL_FETCH: begin
                // data returns in order, so the last count means the line is complete
                if (mem_data_ok && (data_cnt_q == LAST_WORD)) begin
                    state_d = icache_pkg::REFILL_WRITE;
                end
            end
            icache_pkg::REFILL_WRITE: begin
                state_d = icache_pkg::REFILL_IDLE;
            end
            default: begin
                state_d = icache_pkg::REFILL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= icache_pkg::REFILL_IDLE;
            addr_cnt_q <= '0;
            data_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == icache_pkg::REFILL_IDLE) begin
                addr_cnt_q <= '0;
                data_cnt_q <= '0;
            end else begin
                if (mem_req && mem_addr_ok) begin
                    addr_cnt_q <= addr_cnt_q + 1'b1;
                end
                if (data_beat) begin
                    data_cnt_q <= data_cnt_q + 1'b1;
                end
            end
        end
    end

    // assemble the line word by word
    always_ff @(posedge clk) begin
        if (data_beat) begin
            fill_line[data_cnt_q * 32 +: 32] <= mem_read_data;
        end
    end

    // the cpu holds instr_addr_1 during the miss, so the address stays stable under stalls
    assign miss_tag    = instr_addr_1[31:TAG_LSB];
    assign miss_index  = instr_addr_1[TAG_LSB-1:OFFSET_WIDTH];
    assign line_base   = {miss_tag, miss_index, {OFFSET_WIDTH{1'b0}}};
    assign beat_offset = {{(32 - OFFSET_WIDTH){1'b0}}, addr_cnt_q[WORD_SEL_WIDTH-1:0], 2'b00};

    assign mem_req       = fetching && !addr_done;
    assign mem_read_addr = line_base + beat_offset;

endmodule

`default_nettype wire

// ==== icache_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

    localparam int INDEX_WIDTH    = icache_pkg::DEFAULT_INDEX_WIDTH;
    localparam int OFFSET_WIDTH   = icache_pkg::DEFAULT_OFFSET_WIDTH;
    localparam int WAY_NUM        = icache_pkg::DEFAULT_WAY_NUM;
    localparam int TAG_LSB        = INDEX_WIDTH + OFFSET_WIDTH;
    localparam int SET_NUM        = 2 ** INDEX_WIDTH;
    localparam int LINE_WORDS     = 2 ** (OFFSET_WIDTH - 2);
    localparam int RANDOM_FETCHES = 400;
    // about 420 fetches at no more than 50 cycles each, with margin
    localparam int MAX_CYCLES     = 25000;

    localparam icache_pkg::addr_t EVICT_BASE = 32'h0000_8050;
    localparam icache_pkg::addr_t RAND_BASE  = 32'h0001_0000;
    localparam icache_pkg::addr_t LINE_MASK  = (1 << OFFSET_WIDTH) - 1;

    logic              clk;
    logic              rst;
    logic              cpu_req_1;
    logic              cpu_req_2;
    icache_pkg::addr_t instr_addr_1;
    icache_pkg::addr_t instr_addr_2;
    logic              cpu_addr_ok;
    logic              cpu_data_ok;
    logic              second_data_ok;
    icache_pkg::word_t instr_rdata_1;
    icache_pkg::word_t instr_rdata_2;
    logic              mem_req;
    icache_pkg::addr_t mem_read_addr;
    icache_pkg::word_t mem_read_data;
    logic              mem_addr_ok;
    logic              mem_data_ok;

    // mirror of the cache contents
    logic                  ref_valid [WAY_NUM][SET_NUM];
    logic [31-TAG_LSB:0]   ref_tag   [WAY_NUM][SET_NUM];
    int                    ref_ptr   [SET_NUM];

    // expectation for the fetch in flight
    logic              exp_hit;
    logic              exp_second;
    icache_pkg::word_t exp_word_1;
    icache_pkg::word_t exp_word_2;
    int                fetch_seq = 0;
    int                done_seq = 0;
    int                cycles = 0;
    integer            seed;

    icache_top DUT (.*);

    icache_tb_mem u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin : watchdog
        icache_pkg::refill_state_e hung_state;
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            hung_state = DUT.u_refill_ctrl.state_q;
            $display("timeout: fetches not done after %0d cycles, refill FSM in %s",
                     MAX_CYCLES, hung_state.name());
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    function automatic icache_pkg::word_t mem_word(icache_pkg::addr_t a);
        icache_pkg::word_t x;
        logic [3:0]        rot;
        x   = a ^ 32'h3c5a_96e1;
        rot = a[5:2];
        return (x << rot) | (x >> (32 - rot));
    endfunction

    // hit when a valid way of the set holds the tag
    function automatic logic predict_hit(icache_pkg::addr_t a);
        logic [INDEX_WIDTH-1:0] idx;
        logic                   hit;
        idx = a[TAG_LSB-1:OFFSET_WIDTH];
        hit = 1'b0;
        for (int w = 0; w < WAY_NUM; w++) begin
            if (ref_valid[w][idx] && ref_tag[w][idx] == a[31:TAG_LSB]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // a refill lands in the set's round-robin victim
    task automatic record_fill(input icache_pkg::addr_t a);
        logic [INDEX_WIDTH-1:0] idx;
        int                     w;
        idx               = a[TAG_LSB-1:OFFSET_WIDTH];
        w                 = ref_ptr[idx];
        ref_valid[w][idx] = 1'b1;
        ref_tag[w][idx]   = a[31:TAG_LSB];
        ref_ptr[idx]      = (w + 1) % WAY_NUM;
    endtask

    task automatic check_word(input icache_pkg::word_t got, input icache_pkg::word_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    // drives one request and holds it until the checker has seen cpu_data_ok
    task automatic fetch(input icache_pkg::addr_t a1, input logic r2,
                         input icache_pkg::addr_t a2);
        cpu_req_1    = 1'b1;
        cpu_req_2    = r2;
        instr_addr_1 = a1;
        instr_addr_2 = a2;
        exp_hit      = predict_hit(a1);
        exp_second   = r2 && (a1[31:OFFSET_WIDTH] == a2[31:OFFSET_WIDTH]);
        exp_word_1   = mem_word(a1);
        exp_word_2   = exp_second ? mem_word(a2) : '0;
        fetch_seq    = fetch_seq + 1;
        wait (done_seq == fetch_seq);
        if (!exp_hit) begin
            record_fill(a1);
        end
    endtask

    // request-cycle flags are sampled at the first rising edge, data half a cycle later
    initial begin
        forever begin
            wait (fetch_seq != done_seq);
            @(posedge clk);
            check_flag(cpu_data_ok, exp_hit, "hit in the request cycle");
            check_flag(cpu_addr_ok, exp_hit, "cpu_addr_ok in the request cycle");
            if (exp_hit) begin
                check_flag(mem_req, 1'b0, "mem_req during a hit");
            end
            @(negedge clk);
            while (!cpu_data_ok) begin
                @(negedge clk);
            end
            check_flag(cpu_addr_ok, 1'b1, "cpu_addr_ok");
            check_word(instr_rdata_1, exp_word_1, "instr_rdata_1");
            check_flag(second_data_ok, exp_second, "second_data_ok");
            check_word(instr_rdata_2, exp_word_2, "instr_rdata_2");
            done_seq = fetch_seq;
        end
    end

    initial begin
        icache_pkg::addr_t a1;
        icache_pkg::addr_t a2;
        logic [31:0]       rnd;
        seed         = 27;
        rst          = 1'b1;
        cpu_req_1    = 1'b0;
        cpu_req_2    = 1'b0;
        instr_addr_1 = '0;
        instr_addr_2 = '0;
        for (int s = 0; s < SET_NUM; s++) begin
            ref_ptr[s] = 0;
            for (int w = 0; w < WAY_NUM; w++) begin
                ref_valid[w][s] = 1'b0;
                ref_tag[w][s]   = '0;
            end
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag(mem_req, 1'b0, "mem_req after reset");
        check_flag(cpu_data_ok, 1'b0, "cpu_data_ok after reset");

        // cold miss, then every word of the new line hits
        fetch(32'h0000_0104, 1'b0, '0);
        for (int w = 0; w < LINE_WORDS; w++) begin
            fetch(32'h0000_0100 + 4 * w, 1'b0, '0);
        end

        // dual fetch within one line, across lines, across tags of one set and with slot 2 idle
        fetch(32'h0000_0204, 1'b1, 32'h0000_020c);
        fetch(32'h0000_0208, 1'b1, 32'h0000_0200);
        fetch(32'h0000_0208, 1'b1, 32'h0000_0100);
        fetch(32'h0000_0200, 1'b1, 32'h0000_0600);
        fetch(32'h0000_020c, 1'b0, 32'h0000_0204);

        // WAY_NUM+1 tags into one set evict the first, the others stay resident
        for (int t = 0; t <= WAY_NUM; t++) begin
            fetch(EVICT_BASE + (t << TAG_LSB), 1'b0, '0);
        end
        for (int t = 1; t <= WAY_NUM; t++) begin
            fetch(EVICT_BASE + (t << TAG_LSB), 1'b0, '0);
        end
        fetch(EVICT_BASE, 1'b0, '0);

        // random fetches over 4 tags and 4 sets under memory stalls
        for (int i = 0; i < RANDOM_FETCHES; i++) begin
            rnd = $random(seed);
            a1  = RAND_BASE + (rnd[1:0] << TAG_LSB) + (rnd[3:2] << OFFSET_WIDTH) + (rnd[5:4] << 2);
            if (rnd[6]) begin
                a2 = (a1 & ~LINE_MASK) | (rnd[8:7] << 2);
            end else begin
                a2 = RAND_BASE + (rnd[10:9] << TAG_LSB) + (rnd[12:11] << OFFSET_WIDTH)
                     + (rnd[14:13] << 2);
            end
            fetch(a1, rnd[15], a2);
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== icache_tb_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_tb_mem (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_req,
    input  icache_pkg::addr_t mem_read_addr,
    output logic              mem_addr_ok,
    output logic              mem_data_ok,
    output icache_pkg::word_t mem_read_data
);

    // accepted beats still waiting for their data, oldest first
    icache_pkg::addr_t pend_addr[$];
    int unsigned       pend_due[$];
    int unsigned       cyc;
    int unsigned       last_due;
    int unsigned       due;
    integer            seed;

    function automatic icache_pkg::word_t mem_word(icache_pkg::addr_t a);
        icache_pkg::word_t x;
        logic [3:0]        rot;
        x   = a ^ 32'h3c5a_96e1;
        rot = a[5:2];
        return (x << rot) | (x >> (32 - rot));
    endfunction

    initial begin
        seed          = 27;
        cyc           = 0;
        last_due      = 0;
        mem_addr_ok   = 1'b0;
        mem_data_ok   = 1'b0;
        mem_read_data = '0;
        forever begin
            @(negedge clk);
            cyc           = cyc + 1;
            mem_data_ok   = 1'b0;
            mem_read_data = '0;
            if (rst) begin
                mem_addr_ok = 1'b0;
                pend_addr.delete();
                pend_due.delete();
            end else begin
                // one word per cycle, in order, once its latency has run out
                if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
                    mem_data_ok   = 1'b1;
                    mem_read_data = mem_word(pend_addr.pop_front());
                    void'(pend_due.pop_front());
                end
                // stall about one cycle in four
                mem_addr_ok = (($random(seed) & 3) != 0);
                if (mem_req && mem_addr_ok) begin
                    // 0 to 5 cycles of latency, never overtaking an older beat
                    due = cyc + 1 + ({$random(seed)} % 6);
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    pend_addr.push_back(mem_read_addr);
                    pend_due.push_back(due);
                    last_due = due;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== icache_top.f ====
icache_pkg.sv
icache_way_store.sv
icache_victim_select.sv
icache_hit_select.sv
icache_refill_ctrl.sv
icache_top.sv
icache_tb_mem.sv
icache_tb.sv

// ==== icache_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_top #(
    parameter int INDEX_WIDTH  = icache_pkg::DEFAULT_INDEX_WIDTH,
    parameter int OFFSET_WIDTH = icache_pkg::DEFAULT_OFFSET_WIDTH,
    parameter int WAY_NUM      = icache_pkg::DEFAULT_WAY_NUM
) (
    input  logic              clk,
    input  logic              rst,

    // cpu fetch port
    input  logic              cpu_req_1,
    input  logic              cpu_req_2,
    input  icache_pkg::addr_t instr_addr_1,
    input  icache_pkg::addr_t instr_addr_2,
    output logic              cpu_addr_ok,
    output logic              cpu_data_ok,
    output logic              second_data_ok,
    output icache_pkg::word_t instr_rdata_1,
    output icache_pkg::word_t instr_rdata_2,

    // memory read port
    output logic              mem_req,
    output icache_pkg::addr_t mem_read_addr,
    input  icache_pkg::word_t mem_read_data,
    input  logic              mem_addr_ok,
    input  logic              mem_data_ok
);

    localparam int TAG_WIDTH  = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WORDS = 2 ** (OFFSET_WIDTH - 2);
    localparam int LINE_BITS  = LINE_WORDS * 32;

    logic [INDEX_WIDTH-1:0]       index;
    logic [TAG_WIDTH-1:0]         tag;
    logic [WAY_NUM-1:0]           way_hit;
    logic [WAY_NUM*LINE_BITS-1:0] way_lines;
    logic [WAY_NUM-1:0]           fill_way_en;
    logic [LINE_BITS-1:0]         fill_line;
    logic                         fill_valid;
    logic                         miss;

    // lookup and fill both use slot 1
    assign index = instr_addr_1[INDEX_WIDTH+OFFSET_WIDTH-1:OFFSET_WIDTH];
    assign tag   = instr_addr_1[31:INDEX_WIDTH+OFFSET_WIDTH];

    for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
        icache_way_store #(
            .INDEX_WIDTH  (INDEX_WIDTH),
            .OFFSET_WIDTH (OFFSET_WIDTH)
        ) u_way_store (
            .clk       (clk),
            .rst       (rst),
            .index     (index),
            .tag       (tag),
            .fill_en   (fill_way_en[w]),
            .fill_line (fill_line),
            .way_hit   (way_hit[w]),
            .rd_line   (way_lines[w*LINE_BITS +: LINE_BITS])
        );
    end

    icache_victim_select #(
        .INDEX_WIDTH (INDEX_WIDTH),
        .WAY_NUM     (WAY_NUM)
    ) u_victim_select (
        .clk         (clk),
        .rst         (rst),
        .index       (index),
        .fill_valid  (fill_valid),
        .fill_way_en (fill_way_en)
    );

    icache_hit_select #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .WAY_NUM      (WAY_NUM)
    ) u_hit_select (
        .cpu_req_1      (cpu_req_1),
        .cpu_req_2      (cpu_req_2),
        .instr_addr_1   (instr_addr_1),
        .instr_addr_2   (instr_addr_2),
        .way_hit        (way_hit),
        .way_lines      (way_lines),
        .miss           (miss),
        .cpu_addr_ok    (cpu_addr_ok),
        .cpu_data_ok    (cpu_data_ok),
        .second_data_ok (second_data_ok),
        .instr_rdata_1  (instr_rdata_1),
        .instr_rdata_2  (instr_rdata_2)
    );

    icache_refill_ctrl #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) u_refill_ctrl (
        .clk           (clk),
        .rst           (rst),
        .miss          (miss),
        .instr_addr_1  (instr_addr_1),
        .mem_addr_ok   (mem_addr_ok),
        .mem_data_ok   (mem_data_ok),
        .mem_read_data (mem_read_data),
        .mem_req       (mem_req),
        .mem_read_addr (mem_read_addr),
        .fill_line     (fill_line),
        .fill_valid    (fill_valid)
    );

endmodule

`default_nettype wire

// ==== icache_victim_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_victim_select #(
    parameter int INDEX_WIDTH = 6,
    parameter int WAY_NUM     = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [INDEX_WIDTH-1:0] index,
    input  logic                   fill_valid,
    output logic [WAY_NUM-1:0]     fill_way_en
);

    localparam int SET_NUM   = 2 ** INDEX_WIDTH;
    localparam int PTR_WIDTH = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1;

    // next way to replace, one pointer per set
    logic [SET_NUM-1:0][PTR_WIDTH-1:0] ptr_q;
    logic [PTR_WIDTH-1:0]              cur_ptr;

    assign cur_ptr = ptr_q[index];

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            fill_way_en[w] = fill_valid && (cur_ptr == PTR_WIDTH'(w));
        end
    end

    // advance at the edge that writes the line
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr_q <= '0;
        end else if (fill_valid) begin
            if (cur_ptr == PTR_WIDTH'(WAY_NUM - 1)) begin
                ptr_q[index] <= '0;
            end else begin
                ptr_q[index] <= cur_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== icache_way_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module icache_way_store #(
    parameter int INDEX_WIDTH  = 6,
    parameter int OFFSET_WIDTH = 4
) (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic [INDEX_WIDTH-1:0]                     index,
    input  logic [31-INDEX_WIDTH-OFFSET_WIDTH:0]       tag,
    input  logic                                       fill_en,
    input  logic [(2**(OFFSET_WIDTH-2))*32-1:0]        fill_line,
    output logic                                       way_hit,
    output logic [(2**(OFFSET_WIDTH-2))*32-1:0]        rd_line
);

    localparam int TAG_WIDTH  = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WORDS = 2 ** (OFFSET_WIDTH - 2);
    localparam int LINE_BITS  = LINE_WORDS * 32;
    localparam int SET_NUM    = 2 ** INDEX_WIDTH;

    // one valid bit per set
    logic [SET_NUM-1:0]   valid_q;
    logic [TAG_WIDTH-1:0] tag_mem  [SET_NUM];
    logic [LINE_BITS-1:0] line_mem [SET_NUM];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[index] <= 1'b1;
        end
    end

    // tag and line land together with the valid bit
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[index]  <= tag;
            line_mem[index] <= fill_line;
        end
    end

    // combinational lookup so the hit is seen in the request cycle
    assign way_hit = valid_q[index] && (tag_mem[index] == tag);
    assign rd_line = line_mem[index];

endmodule

`default_nettype wire
